//--- cnn_accel.f
+incdir+.
cnn_pkg.sv
conv_tap_if.sv
cnn_ctrl.sv
conv_window.sv
conv_mac.sv
max_pool.sv
cnn_accel.sv
cnn_accel_props.sv
cnn_accel_tb.sv

//--- Bender.yml
package:
  name: cnn_accel

sources:
  - include_dirs:
      - .
    files:
      - cnn_pkg.sv
      - conv_tap_if.sv
      - cnn_ctrl.sv
      - conv_window.sv
      - conv_mac.sv
      - max_pool.sv
      - cnn_accel.sv
  - target: test
    files:
      - cnn_accel_props.sv
      - cnn_accel_tb.sv

//--- cnn_accel_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cnn_accel_tb
    import cnn_pkg::*;
();

    localparam int TIMEOUT  = 2 * (2 * 4096 * 14 + 2 * 1024 * 8);
    localparam int N_WRITES = 2 * 4096 + 2 * 1024;

    // row-major taps, q4.16
    localparam pixel_t weights [2][9] = '{
        '{20'h0A89E, 20'h092D5, 20'h06D43, 20'h01004, 20'hF8F71,
          20'hF6E54, 20'hFA6D7, 20'hFC834, 20'hFAC19},
        '{20'hFDB55, 20'h02992, 20'hFC994, 20'h050FD, 20'h02F20,
          20'h0202D, 20'h03BD7, 20'hFD369, 20'h05E68}
    };
    localparam pixel_t bias [2] = '{20'h01310, 20'hF7295};

    logic   clk;
    logic   reset;
    logic   ready;
    pixel_t idata;
    pixel_t cdata_rd;
    logic   busy;
    addr_t  iaddr;
    logic   cwr;
    addr_t  caddr_wr;
    pixel_t cdata_wr;
    logic   crd;
    addr_t  caddr_rd;
    bank_e  csel;

    pixel_t img      [4096];
    pixel_t conv_ref [2][4096];
    pixel_t pool_ref [2][1024];
    pixel_t res_mem  [1:4][4096];    // result memory banks 1..4
    int     wr_cnt   [1:4][4096];
    int     wr_total;
    int     cycles = 0;
    integer seed;

    cnn_accel i_cnn_accel (
        .clk      (clk),
        .reset    (reset),
        .ready    (ready),
        .idata    (idata),
        .cdata_rd (cdata_rd),
        .busy     (busy),
        .iaddr    (iaddr),
        .cwr      (cwr),
        .caddr_wr (caddr_wr),
        .cdata_wr (cdata_wr),
        .crd      (crd),
        .caddr_rd (caddr_rd),
        .csel     (csel)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    endtask

    function automatic pixel_t conv_at(input int k, input int r, input int c);
        longint acc;
        longint rnd;
        pixel_t res;
        acc = 0;
        for (int dr = -1; dr <= 1; dr++)
            for (int dc = -1; dc <= 1; dc++)
                if (r + dr >= 0 && r + dr < 64 && c + dc >= 0 && c + dc < 64)
                    acc += longint'(weights[k][(dr + 1) * 3 + dc + 1])
                         * longint'(img[(r + dr) * 64 + c + dc]);
        acc = acc + (longint'(bias[k]) <<< 16);    // bias at the binary point
        rnd = acc + (acc[15] ? 64'sd65536 : 64'sd0);
        res = rnd[35:16];
        return (res < 0) ? pixel_t'(0) : res;
    endfunction

    function automatic pixel_t pool_at(input int k, input int pr, input int pc);
        pixel_t m;
        pixel_t v;
        m = 0;
        for (int i = 0; i < 4; i++)
        begin
            v = conv_ref[k][(2 * pr + i / 2) * 64 + 2 * pc + i % 2];
            if (v > m)
                m = v;
        end
        return m;
    endfunction

    task automatic build_model();
        for (int a = 0; a < 4096; a++)
        begin
            img[a] = pixel_t'($random(seed) % 262144);    // within +-4.0
            for (int b = 1; b <= 4; b++)
            begin
                res_mem[b][a] = '0;
                wr_cnt[b][a]  = 0;
            end
        end
        for (int k = 0; k < 2; k++)
        begin
            for (int a = 0; a < 4096; a++)
                conv_ref[k][a] = conv_at(k, a / 64, a % 64);
            for (int p = 0; p < 1024; p++)
                pool_ref[k][p] = pool_at(k, p / 32, p % 32);
        end
    endtask

    task automatic check_idle();
        compare("busy", busy, 0);
        compare("cwr", cwr, 0);
        compare("crd", crd, 0);
    endtask

    // cwr seen at the falling edge, write lands on the next rising edge
    task automatic record_write();
        int b;
        int a;
        b = int'(csel);
        a = int'(caddr_wr);
        if (!busy)
            abort_run("result memory written while busy is low");
        if (b < 1 || b > 4)
            abort_run($sformatf("write with invalid bank select %0d", b));
        if (b >= 3 && a >= 1024)
            abort_run($sformatf("pooled write outside the 32x32 map at 0x%h", a));
        if (wr_cnt[b][a] != 0)
            abort_run($sformatf("bank %0d address 0x%h written twice", b, a));
        if (b <= 2)
            compare($sformatf("cdata_wr (bank %0d, caddr_wr 0x%h)", b, a),
                    cdata_wr, conv_ref[b - 1][a]);
        else
            compare($sformatf("cdata_wr (bank %0d, caddr_wr 0x%h)", b, a),
                    cdata_wr, pool_ref[b - 3][a]);
        wr_cnt[b][a]++;
        wr_total++;
        res_mem[b][a] = cdata_wr;
    endtask

    always @(negedge clk)
    begin
        if (i_cnn_accel.i_props.fail_cnt != 0)
            abort_run("a protocol assertion on the memory ports failed");
        if (cwr)
            record_write();
        idata    = img[iaddr];
        cdata_rd = (csel == BANK_L0_K0 || csel == BANK_L0_K1) ?
                   res_mem[int'(csel)][caddr_rd] : '0;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT)
            abort_run("timeout, busy did not fall within the cycle limit");
    end

    initial
    begin
        reset    = 1'b1;
        ready    = 1'b0;
        idata    = '0;
        cdata_rd = '0;
        seed     = 32'h2de6;
        wr_total = 0;
        build_model();
        repeat (3) @(negedge clk);
        reset = 1'b0;
        compare("csel", csel, BANK_NONE);
        compare("iaddr", iaddr, 0);
        compare("caddr_rd", caddr_rd, 0);
        repeat (5)
        begin
            @(negedge clk);
            check_idle();
        end
        ready = 1'b1;
        @(negedge clk);
        ready = 1'b0;
        repeat (3)
            if (!busy)
                @(negedge clk);
        compare("busy", busy, 1);
        while (busy)
            @(negedge clk);
        compare("cwr", cwr, 0);    // nothing left in flight
        for (int b = 1; b <= 4; b++)
            for (int a = 0; a < ((b <= 2) ? 4096 : 1024); a++)
                compare($sformatf("write count of bank %0d address 0x%h", b, a),
                        wr_cnt[b][a], 1);
        repeat (4)
        begin
            @(negedge clk);
            check_idle();
        end
        if (wr_total == N_WRITES)
        begin
            $display("All tests passed");
            $finish;
        end
        else
            abort_run($sformatf("%0d writes seen, %0d expected", wr_total, N_WRITES));
    end

endmodule

`default_nettype wire

//--- cnn_accel_props.sv
`timescale 1ns/100ps
`default_nettype none

module cnn_accel_props
    import cnn_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  ready,
    input logic  busy,
    input logic  cwr,
    input logic  crd,
    input bank_e csel
);

    int fail_cnt = 0;    // failed assertions so far

    assert property (@(posedge clk) disable iff (reset) !(cwr && crd))
    else
    begin
        $error("cwr and crd high in the same cycle");
        fail_cnt++;
    end

    // no run without ready
    assert property (@(posedge clk) disable iff (reset) (!busy && !ready) |=> !busy)
    else
    begin
        $error("busy rose without ready");
        fail_cnt++;
    end

    assert property (@(posedge clk) disable iff (reset) cwr |-> csel != BANK_NONE)
    else
    begin
        $error("write strobe with no bank selected");
        fail_cnt++;
    end

endmodule

bind cnn_accel cnn_accel_props i_props (
    .clk   (clk),
    .reset (reset),
    .ready (ready),
    .busy  (busy),
    .cwr   (cwr),
    .crd   (crd),
    .csel  (csel)
);

`default_nettype wire

//--- cnn_accel.sv
`timescale 1ns/100ps
`default_nettype none

module cnn_accel
    import cnn_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   ready,
    input  pixel_t idata,
    input  pixel_t cdata_rd,
    output logic   busy,
    output addr_t  iaddr,
    output logic   cwr,
    output addr_t  caddr_wr,
    output pixel_t cdata_wr,
    output logic   crd,
    output addr_t  caddr_rd,
    output bank_e  csel
);

    logic   pix_start;
    logic   pool_start;
    logic   frame_last;
    logic   res_valid;
    logic   max_valid;
    logic   kernel_sel;
    pixel_t result;
    pixel_t max_value;
    addr_t  pool_idx;

    conv_tap_if tap_bus ();

    assign kernel_sel = (csel == BANK_L0_K1);    // set together with the kernel register

    cnn_ctrl i_cnn_ctrl (
        .clk        (clk),
        .reset      (reset),
        .ready      (ready),
        .frame_last (frame_last),
        .res_valid  (res_valid),
        .max_valid  (max_valid),
        .result     (result),
        .max_value  (max_value),
        .pix_addr   (tap_bus.pix_addr),
        .pool_idx   (pool_idx),
        .busy       (busy),
        .pix_start  (pix_start),
        .pool_start (pool_start),
        .cwr        (cwr),
        .caddr_wr   (caddr_wr),
        .cdata_wr   (cdata_wr),
        .csel       (csel)
    );

    conv_window i_conv_window (
        .clk        (clk),
        .reset      (reset),
        .pix_start  (pix_start),
        .iaddr      (iaddr),
        .frame_last (frame_last),
        .tap        (tap_bus.scan)
    );

    conv_mac i_conv_mac (
        .clk        (clk),
        .reset      (reset),
        .kernel_sel (kernel_sel),
        .idata      (idata),
        .tap        (tap_bus.mac),
        .res_valid  (res_valid),
        .result     (result)
    );

    max_pool i_max_pool (
        .clk        (clk),
        .reset      (reset),
        .pool_start (pool_start),
        .cdata_rd   (cdata_rd),
        .crd        (crd),
        .caddr_rd   (caddr_rd),
        .pool_idx   (pool_idx),
        .max_valid  (max_valid),
        .max_value  (max_value)
    );

endmodule

`default_nettype wire

//--- max_pool.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_cfg.svh"

module max_pool
    import cnn_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   pool_start,
    input  pixel_t cdata_rd,
    output logic   crd,
    output addr_t  caddr_rd,
    output addr_t  pool_idx,
    output logic   max_valid,
    output pixel_t max_value
);

    localparam int H = `CNN_IMG_LOG2 - 1;

    logic [H-1:0] prow;
    logic [H-1:0] pcol;
    logic [1:0]   ph;          // next read of the 2x2 window
    logic [1:0]   rd_ph;       // read on the bus now
    logic         rd_act;
    logic         win_done;
    pixel_t       run_max;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            prow      <= '0;
            pcol      <= '0;
            ph        <= '0;
            rd_ph     <= '0;
            rd_act    <= 1'b0;
            crd       <= 1'b0;
            caddr_rd  <= '0;
            win_done  <= 1'b0;
            max_valid <= 1'b0;
        end
        else
        begin
            crd       <= rd_act;
            win_done  <= crd && (rd_ph == 2'd3);
            max_valid <= win_done;
            if (pool_start)
            begin
                rd_act <= 1'b1;
                ph     <= '0;
            end
            else if (rd_act)
            begin
                ph <= ph + 1'b1;
                if (ph == 2'd3)
                    rd_act <= 1'b0;
            end
            if (rd_act)
            begin
                caddr_rd <= {prow, ph[1], pcol, ph[0]};    // +0, +1, +64, +65
                rd_ph    <= ph;
            end
            if (max_valid)
                {prow, pcol} <= {prow, pcol} + 1'b1;
        end
    end

    // relu output is never negative, so compare unsigned
    always_ff @(posedge clk)
    begin
        if (crd)
        begin
            if (rd_ph == 2'd0 || $unsigned(cdata_rd) > $unsigned(run_max))
                run_max <= cdata_rd;
        end
        if (win_done)
            max_value <= run_max;
    end

    assign pool_idx = addr_t'({prow, pcol});

endmodule

`default_nettype wire

//--- conv_mac.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_cfg.svh"

module conv_mac
    import cnn_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     kernel_sel,
    input  pixel_t   idata,
    conv_tap_if.mac  tap,
    output logic     res_valid,
    output pixel_t   result
);

    localparam pixel_t k0_w [9] = '{
        20'h0A89E, 20'h092D5, 20'h06D43,
        20'h01004, 20'hF8F71, 20'hF6E54,
        20'hFA6D7, 20'hFC834, 20'hFAC19
    };
    localparam pixel_t k1_w [9] = '{
        20'hFDB55, 20'h02992, 20'hFC994,
        20'h050FD, 20'h02F20, 20'h0202D,
        20'h03BD7, 20'hFD369, 20'h05E68
    };
    localparam pixel_t bias_w [2] = '{20'h01310, 20'hF7295};

    pixel_t weight;
    pixel_t operand;
    acc_t   product;
    acc_t   acc;
    acc_t   biased;
    acc_t   rnd;
    pixel_t relu_in;
    logic   acc_done;
    logic   rnd_done;

    always_comb
    begin
        weight  = kernel_sel ? k1_w[tap.tap_idx] : k0_w[tap.tap_idx];
        operand = tap.tap_pad ? pixel_t'(0) : idata;    // zero padding
        product = acc_t'(weight) * acc_t'(operand);
        biased  = acc + (acc_t'(kernel_sel ? bias_w[1] : bias_w[0]) <<< `CNN_FRAC);
    end

    assign relu_in = rnd[`CNN_FRAC +: `CNN_DATA_W];

    always_ff @(posedge clk)
    begin
        if (tap.tap_en)
            acc <= (tap.tap_idx == 4'd0) ? product : acc + product;
        if (acc_done)
            rnd <= biased + (biased[`CNN_FRAC-1] ? (acc_t'(1) <<< `CNN_FRAC) : acc_t'(0));
        if (rnd_done)
            result <= relu_in[`CNN_DATA_W-1] ? pixel_t'(0) : relu_in;    // relu
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            acc_done  <= 1'b0;
            rnd_done  <= 1'b0;
            res_valid <= 1'b0;
        end
        else
        begin
            acc_done  <= tap.tap_en && tap.tap_last;
            rnd_done  <= acc_done;
            res_valid <= rnd_done;
        end
    end

endmodule

`default_nettype wire

//--- conv_window.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_cfg.svh"

module conv_window
    import cnn_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       pix_start,
    output addr_t      iaddr,
    output logic       frame_last,
    conv_tap_if.scan   tap
);

    localparam int N = `CNN_IMG_LOG2;

    logic [N-1:0]      row;
    logic [N-1:0]      col;
    tap_t              cnt;
    logic              active;
    logic              primed;     // first pixel starts at the origin
    logic signed [1:0] dr;
    logic signed [1:0] dc;
    logic signed [N+1:0] tr;
    logic signed [N+1:0] tc;
    logic              pad;

    always_comb
    begin
        case (cnt)
            4'd0, 4'd1, 4'd2: dr = -2'sd1;
            4'd3, 4'd4, 4'd5: dr = 2'sd0;
            default:          dr = 2'sd1;
        endcase
        case (cnt)
            4'd0, 4'd3, 4'd6: dc = -2'sd1;
            4'd1, 4'd4, 4'd7: dc = 2'sd0;
            default:          dc = 2'sd1;
        endcase
        tr  = $signed({2'b00, row}) + dr;
        tc  = $signed({2'b00, col}) + dc;
        pad = (tr[N+1:N] != 2'b00) || (tc[N+1:N] != 2'b00);    // below 0 or past 63
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            row    <= '0;
            col    <= '0;
            cnt    <= '0;
            active <= 1'b0;
            primed <= 1'b0;
        end
        else if (pix_start)
        begin
            active <= 1'b1;
            cnt    <= '0;
            primed <= 1'b1;
            if (primed)
                {row, col} <= {row, col} + 1'b1;    // raster order, wraps for kernel 1
        end
        else if (active)
        begin
            cnt <= cnt + 1'b1;
            if (cnt == 4'd8)
                active <= 1'b0;
        end
    end

    // address and tap info leave together, data comes back by the next edge
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            iaddr        <= '0;
            tap.tap_en   <= 1'b0;
            tap.tap_pad  <= 1'b0;
            tap.tap_idx  <= '0;
            tap.tap_last <= 1'b0;
        end
        else
        begin
            iaddr        <= pad ? {row, col} : {tr[N-1:0], tc[N-1:0]};
            tap.tap_en   <= active;
            tap.tap_pad  <= pad;
            tap.tap_idx  <= cnt;
            tap.tap_last <= active && (cnt == 4'd8);
        end
    end

    assign tap.pix_addr = {row, col};
    assign frame_last   = &{row, col};

endmodule

`default_nettype wire

//--- cnn_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_cfg.svh"

module cnn_ctrl
    import cnn_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   ready,
    input  logic   frame_last,
    input  logic   res_valid,
    input  logic   max_valid,
    input  pixel_t result,
    input  pixel_t max_value,
    input  addr_t  pix_addr,
    input  addr_t  pool_idx,
    output logic   busy,
    output logic   pix_start,
    output logic   pool_start,
    output logic   cwr,
    output addr_t  caddr_wr,
    output pixel_t cdata_wr,
    output bank_e  csel
);

    ctrl_state_e                       state;
    logic                              kernel;      // second kernel / second bank
    logic [2*(`CNN_IMG_LOG2-1)-1:0]    pool_cnt;    // pooled output of the current bank

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state      <= IDLE;
            kernel     <= 1'b0;
            pool_cnt   <= '0;
            busy       <= 1'b0;
            pix_start  <= 1'b0;
            pool_start <= 1'b0;
            cwr        <= 1'b0;
            csel       <= BANK_NONE;
        end
        else
        begin
            pix_start  <= 1'b0;
            pool_start <= 1'b0;
            cwr        <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (ready)
                    begin
                        busy      <= 1'b1;
                        csel      <= BANK_L0_K0;
                        pix_start <= 1'b1;
                        state     <= CONV;
                    end
                end
                CONV:
                begin
                    if (res_valid)
                    begin
                        cwr   <= 1'b1;
                        state <= CONV_WRITE;
                    end
                end
                CONV_WRITE:
                begin
                    if (!frame_last)
                    begin
                        pix_start <= 1'b1;
                        state     <= CONV;
                    end
                    else if (!kernel)
                    begin
                        kernel    <= 1'b1;
                        csel      <= BANK_L0_K1;
                        pix_start <= 1'b1;
                        state     <= CONV;
                    end
                    else
                    begin
                        kernel     <= 1'b0;
                        csel       <= BANK_L0_K0;    // read side of pooling
                        pool_start <= 1'b1;
                        state      <= POOL;
                    end
                end
                POOL:
                begin
                    if (max_valid)
                    begin
                        cwr   <= 1'b1;
                        csel  <= kernel ? BANK_L1_K1 : BANK_L1_K0;
                        state <= POOL_WRITE;
                    end
                end
                POOL_WRITE:
                begin
                    pool_cnt <= pool_cnt + 1'b1;
                    if (!(&pool_cnt))
                    begin
                        csel       <= kernel ? BANK_L0_K1 : BANK_L0_K0;
                        pool_start <= 1'b1;
                        state      <= POOL;
                    end
                    else if (!kernel)
                    begin
                        kernel     <= 1'b1;
                        csel       <= BANK_L0_K1;
                        pool_start <= 1'b1;
                        state      <= POOL;
                    end
                    else
                    begin
                        busy  <= 1'b0;    // falls with the last pooled write
                        csel  <= BANK_NONE;
                        state <= DONE;
                    end
                end
                DONE:
                begin
                    busy <= 1'b0;
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == CONV && res_valid)
        begin
            caddr_wr <= pix_addr;
            cdata_wr <= result;
        end
        else if (state == POOL && max_valid)
        begin
            caddr_wr <= pool_idx;
            cdata_wr <= max_value;
        end
    end

endmodule

`default_nettype wire

//--- conv_tap_if.sv
`timescale 1ns/100ps
`default_nettype none

interface conv_tap_if
    import cnn_pkg::*;
();

    logic  tap_en;      // tap in flight, aligned with idata
    logic  tap_pad;     // outside the image
    tap_t  tap_idx;
    logic  tap_last;    // ninth tap
    addr_t pix_addr;    // centre pixel

    modport scan (output tap_en, tap_pad, tap_idx, tap_last, pix_addr);

    modport mac (input tap_en, tap_pad, tap_idx, tap_last);

endinterface

`default_nettype wire

//--- cnn_pkg.sv
`default_nettype none

`include "cnn_cfg.svh"

package cnn_pkg;

    typedef logic signed [`CNN_DATA_W-1:0] pixel_t;
    typedef logic        [`CNN_ADDR_W-1:0] addr_t;
    typedef logic signed [`CNN_ACC_W-1:0]  acc_t;
    typedef logic        [3:0]             tap_t;   // 0..8, row-major over the window

    // csel codes of the result memory
    typedef enum logic [2:0] {
        BANK_NONE  = 3'd0,
        BANK_L0_K0 = 3'd1,
        BANK_L0_K1 = 3'd2,
        BANK_L1_K0 = 3'd3,
        BANK_L1_K1 = 3'd4
    } bank_e;

    typedef enum logic [2:0] {
        IDLE,
        CONV,
        CONV_WRITE,
        POOL,
        POOL_WRITE,
        DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- cnn_cfg.svh
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// pixel and result word, signed fixed point
`define CNN_DATA_W 20

// image and result memory address
`define CNN_ADDR_W 12

// 64x64 image
`define CNN_IMG_LOG2 6

// fraction bits of a pixel word
`define CNN_FRAC 16

// 40-bit products plus 9-tap growth
`define CNN_ACC_W 44

`endif
